/* filelist.f */
+incdir+design
design/bank_sched_pkg.sv
design/sched_queue_if.sv
design/sched_fifo.sv
design/bank_sched_dp.sv
design/bank_sched_ctrl.sv
design/bank_sched_top.sv
dv/bank_sched_tb.sv

/* dv/bank_sched_tb.sv */
`default_nettype none

`include "bank_sched_cfg.svh"

module bank_sched_tb;
   timeunit 1ns;
   timeprecision 1ps;
   import bank_sched_pkg::*;

   localparam int NUM_REQ = 2000;               // Requests in the random run
   localparam int TIMEOUT = NUM_REQ * 10;       // Cycle budget for the whole run

   typedef struct packed {
      logic typ;                                // READ or WRITE code
      ra_t  ra;
      ca_t  ca;
      idx_t idx;
      dq_t  dq;                                 // Zero for reads
   } cmd_t;

   logic clk;
   logic arst_n_i;
   logic req_valid_i;
   logic req_ready_o;
   logic req_type_i;
   ra_t  req_ra_i;
   ca_t  req_ca_i;
   idx_t req_idx_i;
   dq_t  req_dq_i;
   logic cmd_valid_o;
   logic cmd_ready_i;
   logic cmd_type_o;
   ra_t  cmd_ra_o;
   ca_t  cmd_ca_o;
   idx_t cmd_idx_o;
   dq_t  cmd_dq_o;

   cmd_t   m_q [`BS_Q_NUM][`BS_RD_DEPTH];       // Model queues with head at slot 0
   int     m_cnt [`BS_Q_NUM];
   ra_t    m_open_ra;                           // Model open row
   logic   m_open_vld;
   integer seed;
   int     cycle_cnt;
   int     n_gen;                               // Requests put on the bus
   int     n_acc;
   int     n_iss;
   int     burst_left;                          // Cycles of forced cmd_ready low
   logic   take;                                // Handshakes seen at the last check
   logic   iss;
   int     take_tgt;
   int     pick;
   cmd_t   take_ent;
   cmd_t   prev_cmd;                            // Fields shown at the last check
   logic   prev_hold;                           // Last cycle left the state alone

   bank_sched_top DUT (.*);

   initial begin
      clk = 1'b0;
      forever #10 clk = ~clk;
   end

   always @(posedge clk) begin
      cycle_cnt++;
      if (cycle_cnt >= TIMEOUT) begin
         $display("Timeout after %0d cycles, %0d of %0d requests issued",
                  cycle_cnt, n_iss, NUM_REQ);
         abort_run();
      end
   end

   // ************************************************************************
   // Reporting and compare tasks
   // ************************************************************************
   task automatic abort_run();
      $display("Simulation failed");
      $fatal(1, "run stopped at first error");
   endtask

   task automatic check_ready(input logic exp, input logic act);
      if (act !== exp) begin
         $display("** Error: req_ready_o expected %h got %h", exp, act);
         abort_run();
      end
   endtask

   task automatic check_valid(input logic exp, input logic act);
      if (act !== exp) begin
         $display("** Error: cmd_valid_o expected %h got %h", exp, act);
         abort_run();
      end
   endtask

   task automatic check_cmd(input cmd_t exp, input cmd_t act);
      if (act !== exp) begin
         $display("** Error: cmd_type/ra/ca/idx/dq_o expected %h %h %h %h %h got %h %h %h %h %h",
                  exp.typ, exp.ra, exp.ca, exp.idx, exp.dq,
                  act.typ, act.ra, act.ca, act.idx, act.dq);
         abort_run();
      end
   endtask

   // ************************************************************************
   // Reference model
   // ************************************************************************
   function automatic int q_depth(input int i);
      return (i < `BS_RD_NUM) ? `BS_RD_DEPTH : `BS_WR_DEPTH;
   endfunction

   function automatic int rand_below(input int n);
      return int'($unsigned($random(seed)) % n);
   endfunction

   function automatic ra_t row_of(input int k);
      case (k)                                  // Small pool forces hits and stalls
         0:       return 16'h0012;
         1:       return 16'h0345;
         2:       return 16'h1a2b;
         3:       return 16'h4000;
         4:       return 16'h7ffe;
         default: return 16'hbeef;
      endcase
   endfunction

   // Ready by the allocation rules and the queue that takes the request
   function automatic logic model_ready(input logic typ, input ra_t ra, output int tgt);
      int lo;
      int hi;
      lo = (typ == `BS_READ) ? 0 : `BS_RD_NUM;
      hi = (typ == `BS_READ) ? `BS_RD_NUM : `BS_Q_NUM;
      tgt = -1;
      for (int i = lo; i < hi; i++) begin
         if (m_cnt[i] != 0 && m_q[i][m_cnt[i] - 1].ra == ra) begin
            tgt = i;                            // Same row must join its own queue
            return m_cnt[i] < q_depth(i);
         end
      end
      for (int i = lo; i < hi; i++) begin
         if (m_cnt[i] == 0) begin
            tgt = i;                            // Lowest empty queue opens
            return 1'b1;
         end
      end
      return 1'b0;
   endfunction

   // Queue to issue from or -1 when all queues are empty
   function automatic int model_select();
      for (int i = 0; i < `BS_Q_NUM && m_open_vld; i++) begin
         if (m_cnt[i] != 0 && m_q[i][0].ra == m_open_ra) return i;  // Row hit
      end
      for (int i = `BS_RD_NUM; i < `BS_Q_NUM; i++) begin
         if (m_cnt[i] == q_depth(i)) return i;                       // Write drain
      end
      for (int i = 0; i < `BS_Q_NUM; i++) begin
         if (m_cnt[i] != 0) return i;           // Reads sit below writes
      end
      return -1;
   endfunction

   // ************************************************************************
   // One clock of stimulus and checks
   // ************************************************************************
   task automatic run_cycle(input logic drain);
      logic exp_rdy;
      int   tgt;
      cmd_t act;
      @(posedge clk);
      if (iss) begin                            // Pop first since both use pre-edge state
         m_open_ra  = m_q[pick][0].ra;
         m_open_vld = 1'b1;
         for (int k = 1; k < m_cnt[pick]; k++) begin
            m_q[pick][k - 1] = m_q[pick][k];
         end
         m_cnt[pick]--;
         n_iss++;
      end
      if (take) begin
         m_q[take_tgt][m_cnt[take_tgt]] = take_ent;
         m_cnt[take_tgt]++;
         n_acc++;
      end
      if (drain) begin
         req_valid_i <= 1'b0;
         cmd_ready_i <= 1'b1;
      end else begin
         if (!req_valid_i || take) begin        // Held until accepted
            if (n_gen < NUM_REQ && rand_below(10) < 7) begin
               req_valid_i <= 1'b1;
               req_type_i  <= rand_below(2) == 0;
               req_ra_i    <= row_of(rand_below(6));
               req_ca_i    <= ca_t'($random(seed));
               req_idx_i   <= idx_t'(n_gen);    // Counter keeps pending tags unique
               req_dq_i    <= dq_t'($random(seed));
               n_gen++;
            end else begin
               req_valid_i <= 1'b0;
            end
         end
         if (burst_left > 0) begin
            burst_left--;
            cmd_ready_i <= 1'b0;
         end else if (rand_below(40) == 0) begin
            burst_left = 9 + rand_below(21);    // 10 to 30 cycles of back-pressure
            cmd_ready_i <= 1'b0;
         end else begin
            cmd_ready_i <= rand_below(10) < 6;
         end
      end
      @(negedge clk);                           // Outputs settled mid-cycle
      exp_rdy = model_ready(req_type_i, req_ra_i, tgt);
      check_ready(exp_rdy, req_ready_o);
      pick = model_select();
      check_valid(pick >= 0, cmd_valid_o);
      act = '{typ: cmd_type_o, ra: cmd_ra_o, ca: cmd_ca_o, idx: cmd_idx_o, dq: cmd_dq_o};
      if (prev_hold) check_cmd(prev_cmd, act);  // Stalled without push so nothing moves
      if (pick >= 0) begin
         check_cmd(m_q[pick][0], act);
      end
      take      = req_valid_i && exp_rdy;
      take_tgt  = tgt;
      take_ent  = '{typ: req_type_i, ra: req_ra_i, ca: req_ca_i, idx: req_idx_i,
                    dq: (req_type_i == `BS_READ) ? dq_t'(0) : req_dq_i};
      iss       = (pick >= 0) && cmd_ready_i;
      prev_cmd  = act;
      prev_hold = (pick >= 0) && !iss && !take;
   endtask

   // ************************************************************************
   // Main sequence
   // ************************************************************************
   initial begin
      seed        = 32'h6a3d0a94;
      arst_n_i    = 1'b1;
      req_valid_i = 1'b0;
      req_type_i  = `BS_READ;
      req_ra_i    = '0;
      req_ca_i    = '0;
      req_idx_i   = '0;
      req_dq_i    = '0;
      cmd_ready_i = 1'b0;
      cycle_cnt   = 0;
      n_gen       = 0;
      n_acc       = 0;
      n_iss       = 0;
      burst_left  = 0;
      take        = 1'b0;
      iss         = 1'b0;
      prev_hold   = 1'b0;
      m_open_vld  = 1'b0;
      foreach (m_cnt[i]) m_cnt[i] = 0;
      @(posedge clk);
      arst_n_i <= 1'b0;
      repeat (4) @(posedge clk);
      arst_n_i <= 1'b1;
      @(negedge clk);
      check_ready(1'b1, req_ready_o);           // All queues empty after reset
      check_valid(1'b0, cmd_valid_o);
      while (n_acc < NUM_REQ) run_cycle(1'b0);
      while (cmd_valid_o) run_cycle(1'b1);      // Drain until the DUT goes idle
      if (n_iss != NUM_REQ || model_select() != -1) begin
         $display("Drain incomplete, %0d of %0d requests issued", n_iss, NUM_REQ);
         abort_run();
      end else begin
         $display("Simulation completed successfully");
         $finish;
      end
   end

endmodule

`default_nettype wire

/* design/bank_sched_top.sv */
`default_nettype none

module bank_sched_top (
   input  logic                  clk,
   input  logic                  arst_n_i,
   // Request side from the transaction controller
   input  logic                  req_valid_i,
   output logic                  req_ready_o,
   input  logic                  req_type_i,
   input  bank_sched_pkg::ra_t   req_ra_i,
   input  bank_sched_pkg::ca_t   req_ca_i,
   input  bank_sched_pkg::idx_t  req_idx_i,
   input  bank_sched_pkg::dq_t   req_dq_i,
   // Command side toward the DRAM
   output logic                  cmd_valid_o,
   input  logic                  cmd_ready_i,
   output logic                  cmd_type_o,
   output bank_sched_pkg::ra_t   cmd_ra_o,
   output bank_sched_pkg::ca_t   cmd_ca_o,
   output bank_sched_pkg::idx_t  cmd_idx_o,
   output bank_sched_pkg::dq_t   cmd_dq_o
);
   import bank_sched_pkg::*;

   q_vec_t sel;                                 // Issue choice, ctrl to dp

   sched_queue_if q_if ();                      // Push, pop and queue state

   bank_sched_ctrl u_ctrl (
      .clk         (clk),
      .arst_n_i    (arst_n_i),
      .q           (q_if.ctrl),
      .req_valid_i (req_valid_i),
      .req_type_i  (req_type_i),
      .req_ra_i    (req_ra_i),
      .req_ready_o (req_ready_o),
      .cmd_ready_i (cmd_ready_i),
      .cmd_valid_o (cmd_valid_o),
      .sel_o       (sel)
   );

   bank_sched_dp u_dp (
      .clk        (clk),
      .arst_n_i   (arst_n_i),
      .q          (q_if.dp),
      .req_ra_i   (req_ra_i),
      .req_ca_i   (req_ca_i),
      .req_idx_i  (req_idx_i),
      .req_dq_i   (req_dq_i),
      .sel_i      (sel),
      .cmd_type_o (cmd_type_o),
      .cmd_ra_o   (cmd_ra_o),
      .cmd_ca_o   (cmd_ca_o),
      .cmd_idx_o  (cmd_idx_o),
      .cmd_dq_o   (cmd_dq_o)
   );

endmodule

`default_nettype wire

/* design/bank_sched_ctrl.sv */
`default_nettype none

`include "bank_sched_cfg.svh"

module bank_sched_ctrl (
   input  logic                   clk,
   input  logic                   arst_n_i,
   sched_queue_if.ctrl            q,
   input  logic                   req_valid_i,
   input  logic                   req_type_i,    // READ or WRITE code
   input  bank_sched_pkg::ra_t    req_ra_i,
   output logic                   req_ready_o,
   input  logic                   cmd_ready_i,
   output logic                   cmd_valid_o,
   output bank_sched_pkg::q_vec_t sel_o          // One-hot queue to issue from
);
   import bank_sched_pkg::*;

   localparam q_vec_t RD_MASK = q_vec_t'((1 << `BS_RD_NUM) - 1);
   localparam q_vec_t WR_MASK = ~RD_MASK;

   q_vec_t type_mask;                           // Queues of the request type
   q_vec_t match;                               // Non-empty queue with same row
   q_vec_t free;                                // Empty queue of the request type
   q_vec_t target;                              // Allocation choice
   q_vec_t hit;                                 // Head row equals open row
   q_vec_t drain;                               // Write queue needing drain
   q_vec_t rd_busy;
   q_vec_t wr_busy;
   ra_t    sel_ra;                              // Row of the issued head
   ra_t    open_ra;                             // Currently open row
   logic   open_vld;
   logic   issue;

   // Isolate the lowest set bit
   function automatic q_vec_t lowest_one(input q_vec_t v);
      return v & (~v + 1'b1);
   endfunction

   // ************************************************************************
   // Allocation and input stall
   // ************************************************************************
   always_comb begin
      type_mask = (req_type_i == `BS_READ) ? RD_MASK : WR_MASK;
      for (int i = 0; i < `BS_Q_NUM; i++) begin
         match[i] = type_mask[i] & ~q.empty[i] & (q.tail_ra[i] == req_ra_i);
      end
      free = type_mask & q.empty;
      if (|match) begin
         // Row already queued so only that queue may take it
         target      = lowest_one(match);
         req_ready_o = |(target & ~q.full);
      end else begin
         // New row opens the lowest empty queue
         target      = lowest_one(free);
         req_ready_o = |free;
      end
   end

   assign q.push = (req_valid_i && req_ready_o) ? target : '0;

   // ************************************************************************
   // Issue selection
   // ************************************************************************
   always_comb begin
      for (int i = 0; i < `BS_Q_NUM; i++) begin
         hit[i] = open_vld & ~q.empty[i] & (q.head_ra[i] == open_ra);
      end
      drain   = q.full & WR_MASK;                // Full write queue
      rd_busy = ~q.empty & RD_MASK;
      wr_busy = ~q.empty & WR_MASK;
      if (|hit) begin
         sel_o = lowest_one(hit);               // Lowest row hit so reads beat writes
      end else if (|drain) begin
         sel_o = lowest_one(drain);             // Relieve write pressure
      end else if (|rd_busy) begin
         sel_o = lowest_one(rd_busy);
      end else begin
         sel_o = lowest_one(wr_busy);           // Zero when all empty
      end
   end

   assign cmd_valid_o = |(~q.empty);
   assign issue       = cmd_valid_o & cmd_ready_i;
   assign q.pop       = issue ? sel_o : '0;

   // Row of the selected head
   always_comb begin
      sel_ra = '0;
      for (int i = 0; i < `BS_Q_NUM; i++) begin
         if (sel_o[i]) begin
            sel_ra = q.head_ra[i];
         end
      end
   end

   // ************************************************************************
   // Open row
   // ************************************************************************
   always_ff @(posedge clk or negedge arst_n_i) begin
      if (!arst_n_i) begin
         open_vld <= 1'b0;                      // No row open after reset
      end else if (issue) begin
         open_vld <= 1'b1;
      end
   end

   always_ff @(posedge clk) begin
      if (issue) begin
         open_ra <= sel_ra;                     // Every command opens its row
      end
   end

endmodule

`default_nettype wire

/* design/bank_sched_dp.sv */
`default_nettype none

`include "bank_sched_cfg.svh"

module bank_sched_dp (
   input  logic                  clk,
   input  logic                  arst_n_i,
   sched_queue_if.dp             q,
   input  bank_sched_pkg::ra_t   req_ra_i,
   input  bank_sched_pkg::ca_t   req_ca_i,
   input  bank_sched_pkg::idx_t  req_idx_i,
   input  bank_sched_pkg::dq_t   req_dq_i,
   input  bank_sched_pkg::q_vec_t sel_i,         // One-hot queue shown on cmd
   output logic                  cmd_type_o,
   output bank_sched_pkg::ra_t   cmd_ra_o,
   output bank_sched_pkg::ca_t   cmd_ca_o,
   output bank_sched_pkg::idx_t  cmd_idx_o,
   output bank_sched_pkg::dq_t   cmd_dq_o
);
   import bank_sched_pkg::*;

   rd_entry_t              rd_in;               // Request as a read entry
   wr_entry_t              wr_in;               // Request as a write entry
   rd_entry_t              rd_head [`BS_RD_NUM];
   rd_entry_t              rd_tail [`BS_RD_NUM];
   wr_entry_t              wr_head [`BS_WR_NUM];
   wr_entry_t              wr_tail [`BS_WR_NUM];
   logic [`BS_RD_NUM-1:0]  rd_full;
   logic [`BS_RD_NUM-1:0]  rd_mid;
   logic [`BS_RD_NUM-1:0]  rd_empty;
   logic [`BS_WR_NUM-1:0]  wr_full;
   logic [`BS_WR_NUM-1:0]  wr_mid;
   logic [`BS_WR_NUM-1:0]  wr_empty;

   // Both entry forms built from the same request fields
   assign rd_in = '{ra: req_ra_i, ca: req_ca_i, idx: req_idx_i};
   assign wr_in = '{ra: req_ra_i, ca: req_ca_i, idx: req_idx_i, dq: req_dq_i};

   // ************************************************************************
   // Queue arrays
   // ************************************************************************
   for (genvar i = 0; i < `BS_RD_NUM; i++) begin : g_rd
      sched_fifo #(
         .entry_t (rd_entry_t)
      ) u_fifo (
         .clk      (clk),
         .arst_n_i (arst_n_i),
         .push_i   (q.push[i]),
         .pop_i    (q.pop[i]),
         .data_i   (rd_in),
         .head_o   (rd_head[i]),
         .tail_o   (rd_tail[i]),
         .full_o   (rd_full[i]),
         .mid_o    (rd_mid[i]),
         .empty_o  (rd_empty[i])
      );
   end

   for (genvar i = 0; i < `BS_WR_NUM; i++) begin : g_wr
      sched_fifo #(
         .entry_t (wr_entry_t)
      ) u_fifo (
         .clk      (clk),
         .arst_n_i (arst_n_i),
         .push_i   (q.push[`BS_RD_NUM + i]),    // Write queues sit above reads
         .pop_i    (q.pop[`BS_RD_NUM + i]),
         .data_i   (wr_in),
         .head_o   (wr_head[i]),
         .tail_o   (wr_tail[i]),
         .full_o   (wr_full[i]),
         .mid_o    (wr_mid[i]),
         .empty_o  (wr_empty[i])
      );
   end

   // ************************************************************************
   // Queue state toward the controller
   // ************************************************************************
   assign q.full  = {wr_full, rd_full};
   assign q.mid   = {wr_mid, rd_mid};
   assign q.empty = {wr_empty, rd_empty};

   always_comb begin
      for (int i = 0; i < `BS_RD_NUM; i++) begin
         q.head_ra[i] = rd_head[i].ra;
         q.tail_ra[i] = rd_tail[i].ra;
      end
      for (int i = 0; i < `BS_WR_NUM; i++) begin
         q.head_ra[`BS_RD_NUM + i] = wr_head[i].ra;
         q.tail_ra[`BS_RD_NUM + i] = wr_tail[i].ra;
      end
   end

   // ************************************************************************
   // Command mux, head of the selected queue
   // ************************************************************************
   always_comb begin
      cmd_type_o = `BS_READ;                    // Idle value when nothing selected
      cmd_ra_o   = '0;
      cmd_ca_o   = '0;
      cmd_idx_o  = '0;
      cmd_dq_o   = '0;
      for (int i = 0; i < `BS_RD_NUM; i++) begin
         if (sel_i[i]) begin
            cmd_type_o = `BS_READ;
            cmd_ra_o   = rd_head[i].ra;
            cmd_ca_o   = rd_head[i].ca;
            cmd_idx_o  = rd_head[i].idx;
            cmd_dq_o   = '0;                    // Reads carry no data
         end
      end
      for (int i = 0; i < `BS_WR_NUM; i++) begin
         if (sel_i[`BS_RD_NUM + i]) begin
            cmd_type_o = `BS_WRITE;
            cmd_ra_o   = wr_head[i].ra;
            cmd_ca_o   = wr_head[i].ca;
            cmd_idx_o  = wr_head[i].idx;
            cmd_dq_o   = wr_head[i].dq;
         end
      end
   end

endmodule

`default_nettype wire

/* design/sched_fifo.sv */
`default_nettype none

`include "bank_sched_cfg.svh"

module sched_fifo #(
   parameter type entry_t = bank_sched_pkg::rd_entry_t
) (
   input  logic   clk,
   input  logic   arst_n_i,
   input  logic   push_i,                       // Write data_i at the tail
   input  logic   pop_i,                        // Drop the head entry
   input  entry_t data_i,
   output entry_t head_o,                       // Oldest entry
   output entry_t tail_o,                       // Newest entry, valid when not empty
   output logic   full_o,
   output logic   mid_o,
   output logic   empty_o
);
   import bank_sched_pkg::*;

   // Write entries live in the short queues, read entries in the deep ones
   localparam int DEPTH = ($bits(entry_t) == $bits(wr_entry_t)) ? `BS_WR_DEPTH
                                                               : `BS_RD_DEPTH;
   localparam int PW    = (DEPTH > 1) ? $clog2(DEPTH) : 1;     // Pointer width
   localparam int CW    = $clog2(DEPTH + 1);                   // Occupancy width

   entry_t        mem [DEPTH];                  // Entry storage
   logic [PW-1:0] wr_ptr;                       // Next free slot
   logic [PW-1:0] rd_ptr;                       // Oldest slot
   logic [PW-1:0] tail_ptr;                     // Last written slot
   logic [CW-1:0] count;                        // Entries held
   logic          do_wr;
   logic          do_rd;

   // Advance a pointer with wrap at DEPTH
   function automatic logic [PW-1:0] ptr_inc(input logic [PW-1:0] p);
      return (p == PW'(DEPTH - 1)) ? '0 : p + 1'b1;
   endfunction

   // ************************************************************************
   // Flags and access
   // ************************************************************************
   assign full_o   = (count == CW'(DEPTH));
   assign empty_o  = (count == '0);
   assign mid_o    = (count >= CW'(DEPTH / 2));          // Half depth or more

   assign do_wr    = push_i & ~full_o;                   // Never overwrite
   assign do_rd    = pop_i & ~empty_o;                   // Never underflow

   assign tail_ptr = (wr_ptr == '0) ? PW'(DEPTH - 1) : wr_ptr - 1'b1;
   assign head_o   = mem[rd_ptr];
   assign tail_o   = mem[tail_ptr];

   // ************************************************************************
   // Pointers and occupancy
   // ************************************************************************
   always_ff @(posedge clk or negedge arst_n_i) begin
      if (!arst_n_i) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end else begin
         if (do_wr) begin
            wr_ptr <= ptr_inc(wr_ptr);
         end
         if (do_rd) begin
            rd_ptr <= ptr_inc(rd_ptr);
         end
         case ({do_wr, do_rd})
            2'b10:   count <= count + 1'b1;          // Push only
            2'b01:   count <= count - 1'b1;          // Pop only
            default: count <= count;                 // Both or neither
         endcase
      end
   end

   // Storage, no reset on payload
   always_ff @(posedge clk) begin
      if (do_wr) begin
         mem[wr_ptr] <= data_i;
      end
   end

endmodule

`default_nettype wire

/* design/sched_queue_if.sv */
`default_nettype none

`include "bank_sched_cfg.svh"

interface sched_queue_if;
   import bank_sched_pkg::*;

   q_vec_t              push;                   // One-hot push, zero when idle
   q_vec_t              pop;                    // One-hot pop, zero when idle
   q_vec_t              full;                   // Queue holds DEPTH entries
   q_vec_t              mid;                    // Queue at half depth or more
   q_vec_t              empty;                  // Queue holds nothing
   ra_t [`BS_Q_NUM-1:0] tail_ra;                // Row of newest entry per queue
   ra_t [`BS_Q_NUM-1:0] head_ra;                // Row of oldest entry per queue

   // Controller side issues push and pop, sees queue state
   modport ctrl (
      output push,
      output pop,
      input  full,
      input  mid,
      input  empty,
      input  tail_ra,
      input  head_ra
   );

   // Datapath side owns the queues
   modport dp (
      input  push,
      input  pop,
      output full,
      output mid,
      output empty,
      output tail_ra,
      output head_ra
   );

endinterface

`default_nettype wire

/* design/bank_sched_pkg.sv */
`default_nettype none

`include "bank_sched_cfg.svh"

package bank_sched_pkg;

   // ************************************************************************
   // Request fields
   // ************************************************************************
   typedef logic [`BS_RA-1:0]    ra_t;         // Row address
   typedef logic [`BS_CA-1:0]    ca_t;         // Column address
   typedef logic [`BS_IDX-1:0]   idx_t;        // Index tag
   typedef logic [`BS_DQ-1:0]    dq_t;         // Data word

   // One bit per queue, reads in the low bits
   typedef logic [`BS_Q_NUM-1:0] q_vec_t;

   // ************************************************************************
   // Stored entries
   // ************************************************************************
   // Read entry, no data is kept for reads
   typedef struct packed {
      ra_t  ra;                                 // Row of the request
      ca_t  ca;                                 // Column of the request
      idx_t idx;                                // Tag returned with the command
   } rd_entry_t;

   // Write entry, same fields plus the data word
   typedef struct packed {
      ra_t  ra;                                 // Row of the request
      ca_t  ca;                                 // Column of the request
      idx_t idx;                                // Tag returned with the command
      dq_t  dq;                                 // Write data
   } wr_entry_t;

endpackage

`default_nettype wire

/* design/bank_sched_cfg.svh */
`ifndef BANK_SCHED_CFG_SVH
`define BANK_SCHED_CFG_SVH

// ************************************************************************
// Request field widths
// ************************************************************************
`define BS_RA         16                          // Row address
`define BS_CA         10                          // Column address
`define BS_IDX        7                           // Index tag from txn controller
`define BS_DQ         16                          // Write data word

// ************************************************************************
// Queue organisation
// ************************************************************************
`define BS_RD_NUM     4                           // Read queues, ids 0..3
`define BS_WR_NUM     3                           // Write queues, ids 4..6
`define BS_Q_NUM      (`BS_RD_NUM + `BS_WR_NUM)   // All queues of the bank
`define BS_RD_DEPTH   4                           // Entries per read queue
`define BS_WR_DEPTH   2                           // Entries per write queue

// Request type codes
`define BS_READ       1'b1
`define BS_WRITE      1'b0

`endif
